/* sources.f */
logic/thread_select_pkg.sv
logic/issue_if.sv
logic/instruction_fifo.sv
logic/thread_queues.sv
logic/register_scoreboard.sv
logic/issue_arbiter.sv
logic/thread_select_stage.sv
verification/thread_select_tb.sv

/* verification/thread_select_tb.sv */
// Table-driven testbench for the thread select stage, compiled as simulation top with the file list
`timescale 1ns/10ps

module thread_select_tb
    import thread_select_pkg::*;
();

    localparam int num_threads = 4;
    localparam int fifo_depth = 8;
    localparam int idx_bits = thread_idx_bits(num_threads);
    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    localparam int row_cycles = 40;

    // One stimulus row, pos is the expected global issue position or -1 when it is free
    typedef struct {
        string name;
        int thread;
        logic has_dest;
        reg_idx_t dest;
        logic has_src1;
        reg_idx_t src1;
        logic has_src2;
        reg_idx_t src2;
        instr_tag_t tag;
        logic [num_threads - 1:0] en_mask;
        int pos;
    } row_t;

    // A destination waiting to be written back, due at the given cycle
    typedef struct packed {
        logic [31:0] when;
        logic [7:0] thread;
        reg_idx_t regnum;
    } wb_t;

    logic clk;
    logic reset;
    decoded_instr_t id_instruction;
    logic id_instruction_valid;
    logic [idx_bits - 1:0] id_thread_idx;
    logic [num_threads - 1:0] fetch_en;
    logic [num_threads - 1:0] thread_en;
    logic wb_writeback_en;
    logic [idx_bits - 1:0] wb_writeback_thread_idx;
    reg_idx_t wb_writeback_reg;
    logic ts_instruction_valid;
    decoded_instr_t ts_instruction;
    logic [idx_bits - 1:0] ts_thread_idx;

    row_t rows [$];
    decoded_instr_t pend_instr [num_threads][$];
    int pend_cycle [num_threads][$];
    int pend_row [num_threads][$];
    wb_t wb_pending [$];
    wb_t last_wb;
    wb_t clear_wb;
    logic last_wb_valid = 1'b0;
    logic clear_valid = 1'b0;
    reg_bitmap_t busy [num_threads];
    logic [num_threads - 1:0] en_prev = '1;
    logic [15:0] lfsr_state = 16'd50699;
    int cycle = 0;
    int rr_ptr = 0;
    int pushed_count = 0;
    int issued_count = 0;
    int mismatch_errors = 0;
    int other_errors = 0;

    thread_select_stage #(
        .num_threads(num_threads),
        .fifo_depth(fifo_depth)
    ) thread_select_stage_i (
        .clk(clk),
        .reset(reset),
        .id_instruction(id_instruction),
        .id_instruction_valid(id_instruction_valid),
        .id_thread_idx(id_thread_idx),
        .fetch_en(fetch_en),
        .thread_en(thread_en),
        .wb_writeback_en(wb_writeback_en),
        .wb_writeback_thread_idx(wb_writeback_thread_idx),
        .wb_writeback_reg(wb_writeback_reg),
        .ts_instruction_valid(ts_instruction_valid),
        .ts_instruction(ts_instruction),
        .ts_thread_idx(ts_thread_idx)
    );

    always #(clk_period / 2) clk = ~clk;

    // Counts rising edges, so at a falling edge it holds the number of the edge just passed
    always @(posedge clk) cycle <= cycle + 1;

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    // Three LFSR bits give a writeback delay of 1 to 8 cycles
    function automatic int writeback_delay();
        int d;
        d = 0;
        for (int b = 0; b < 3; b++)
            d = (d << 1) | int'(lfsr_next_bit());
        return d + 1;
    endfunction

    // Every register an instruction reads or writes, each only where its flag is set
    function automatic reg_bitmap_t used_registers(input decoded_instr_t instr);
        reg_bitmap_t regs;
        regs = '0;
        if (instr.has_dest)
            regs[instr.dest_reg] = 1'b1;
        if (instr.has_src1)
            regs[instr.src1_reg] = 1'b1;
        if (instr.has_src2)
            regs[instr.src2_reg] = 1'b1;
        return regs;
    endfunction

    task automatic report_mismatch(input string test, input logic [63:0] expected,
        input logic [63:0] actual);
        $display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
        mismatch_errors++;
    endtask

    task automatic report_error(input string text);
        $display("ERROR %s", text);
        other_errors++;
    endtask

    task automatic load_table();
        rows.push_back(row_t'{"idle_latency", 0, 0, 0, 0, 0, 0, 0, 'h0010, 4'hF, 0});
        // Read after write and write after write inside thread 1
        rows.push_back(row_t'{"dep_write", 1, 1, 5, 0, 0, 0, 0, 'h0101, 4'hF, -1});
        rows.push_back(row_t'{"dep_read", 1, 1, 6, 1, 5, 0, 0, 'h0102, 4'hF, -1});
        rows.push_back(row_t'{"dep_waw", 1, 1, 6, 0, 0, 1, 7, 'h0103, 4'hF, -1});
        rows.push_back(row_t'{"dep_other_thread", 2, 1, 5, 1, 5, 1, 5, 'h0201, 4'hF, -1});
        // All threads held while a backlog builds, released by the next group
        rows.push_back(row_t'{"rr_t0_a", 0, 1, 10, 0, 0, 0, 0, 'h0011, 4'h0, -1});
        rows.push_back(row_t'{"rr_t1_a", 1, 1, 11, 0, 0, 0, 0, 'h0111, 4'h0, -1});
        rows.push_back(row_t'{"rr_t2_a", 2, 1, 12, 0, 0, 0, 0, 'h0211, 4'h0, -1});
        rows.push_back(row_t'{"rr_t3_a", 3, 1, 13, 0, 0, 0, 0, 'h0311, 4'h0, -1});
        rows.push_back(row_t'{"rr_t0_b", 0, 0, 0, 0, 0, 0, 0, 'h0012, 4'h0, -1});
        rows.push_back(row_t'{"rr_t1_b", 1, 0, 0, 0, 0, 0, 0, 'h0112, 4'h0, -1});
        rows.push_back(row_t'{"rr_t2_b", 2, 0, 0, 0, 0, 0, 0, 'h0212, 4'h0, -1});
        rows.push_back(row_t'{"rr_t3_b", 3, 0, 0, 0, 0, 0, 0, 'h0312, 4'h0, -1});
        // Thread 3 stays disabled while five more instructions land in its queue
        rows.push_back(row_t'{"bp_1", 3, 0, 0, 0, 0, 0, 0, 'h0321, 4'h7, -1});
        rows.push_back(row_t'{"bp_2", 3, 1, 20, 0, 0, 0, 0, 'h0322, 4'h7, -1});
        rows.push_back(row_t'{"bp_3", 3, 0, 0, 1, 20, 0, 0, 'h0323, 4'h7, -1});
        rows.push_back(row_t'{"bp_4", 3, 1, 21, 0, 0, 1, 13, 'h0324, 4'h7, -1});
        rows.push_back(row_t'{"bp_5", 3, 0, 0, 0, 0, 0, 0, 'h0325, 4'h7, -1});
        rows.push_back(row_t'{"reenable", 0, 0, 0, 1, 10, 0, 0, 'h0013, 4'hF, -1});
    endtask

    task automatic apply_row(input int r);
        decoded_instr_t instr;
        int thr;
        thr = rows[r].thread;
        instr.has_dest = rows[r].has_dest;
        instr.dest_reg = rows[r].dest;
        instr.has_src1 = rows[r].has_src1;
        instr.src1_reg = rows[r].src1;
        instr.has_src2 = rows[r].has_src2;
        instr.src2_reg = rows[r].src2;
        instr.tag = rows[r].tag;
        @(posedge clk);
        thread_en <= rows[r].en_mask;
        id_instruction_valid <= 1'b0;
        // An enabled thread only takes a push while its fetch_en is high
        // Pushes into a held thread stand for decode traffic already on its way
        while (rows[r].en_mask[thr] && !fetch_en[thr])
            @(posedge clk);
        id_instruction <= instr;
        id_instruction_valid <= 1'b1;
        id_thread_idx <= idx_bits'(thr);
        pend_instr[thr].push_back(instr);
        pend_cycle[thr].push_back(cycle + 1);
        pend_row[thr].push_back(r);
        pushed_count++;
        // A thread enabled again with a backlog at the almost-full mark keeps fetch_en low
        // Nothing has left its queue yet, so the slot plus the FIFO hold all its pending pushes
        if (r > 0)
        begin
            for (int u = 0; u < num_threads; u++)
            begin
                if (!rows[r - 1].en_mask[u] && rows[r].en_mask[u]
                    && pend_instr[u].size() >= fifo_depth - 2)
                begin
                    @(negedge clk);
                    assert (!fetch_en[u])
                    else report_mismatch({rows[r].name, " fetch_en"}, 0, fetch_en[u]);
                end
            end
        end
    endtask

    // Issue monitor and reference model, sampled on the falling edge where outputs are stable
    always @(negedge clk)
    begin
        int t;
        int u;
        int r;
        decoded_instr_t exp_instr;
        wb_t wb;
        if (!reset && ts_instruction_valid)
        begin
            t = ts_thread_idx;
            assert (pend_instr[t].size() != 0)
            else report_error($sformatf("thread %0d issued with nothing pending", t));
            if (pend_instr[t].size() != 0)
            begin
                r = pend_row[t][0];
                exp_instr = pend_instr[t][0];
                // The whole instruction must match the oldest one pushed to this thread
                assert (ts_instruction == exp_instr)
                else report_mismatch(rows[r].name, exp_instr, ts_instruction);
                if (rows[r].pos >= 0)
                begin
                    assert (issued_count == rows[r].pos)
                    else report_mismatch({rows[r].name, " position"}, rows[r].pos, issued_count);
                end
                // Position 0 is the lone push into an idle stage right after reset
                if (rows[r].pos == 0)
                begin
                    assert (cycle - pend_cycle[t][0] == 3)
                    else report_mismatch({rows[r].name, " latency"}, 3, cycle - pend_cycle[t][0]);
                end
                assert (en_prev[t])
                else report_error({rows[r].name, " issued while its thread was disabled"});
                assert ((busy[t] & used_registers(exp_instr)) == '0)
                else report_error({rows[r].name, " issued while a register it uses was busy"});
                // A thread passed over by the pointer must not have been able to issue
                // Its head reaches the slot two cycles after the push
                for (u = rr_ptr; u != t; u = (u + 1) % num_threads)
                begin
                    assert (!(pend_instr[u].size() != 0 && pend_cycle[u][0] <= cycle - 3
                        && en_prev[u] && (busy[u] & used_registers(pend_instr[u][0])) == '0))
                    else report_error($sformatf("thread %0d was ready but skipped", u));
                end
                rr_ptr = (t + 1) % num_threads;
                if (exp_instr.has_dest)
                begin
                    busy[t][exp_instr.dest_reg] = 1'b1;
                    wb.when = cycle + writeback_delay();
                    wb.thread = t;
                    wb.regnum = exp_instr.dest_reg;
                    wb_pending.push_back(wb);
                end
                pend_instr[t].pop_front();
                pend_cycle[t].pop_front();
                pend_row[t].pop_front();
                issued_count++;
            end
        end
        // Enables seen here are the ones the arbiter uses until the next falling edge
        en_prev = thread_en;
    end

    // Writeback responder, one writeback per cycle, oldest due entry first
    // The model frees a register one cycle after the DUT does, matching when a grant can see it
    always @(posedge clk)
    begin
        int found;
        if (clear_valid)
            busy[clear_wb.thread][clear_wb.regnum] = 1'b0;
        clear_valid = last_wb_valid;
        clear_wb = last_wb;
        last_wb_valid = 1'b0;
        wb_writeback_en <= 1'b0;
        found = -1;
        for (int i = wb_pending.size() - 1; i >= 0; i--)
        begin
            if (wb_pending[i].when <= cycle)
                found = i;
        end
        if (found >= 0)
        begin
            last_wb = wb_pending[found];
            last_wb_valid = 1'b1;
            wb_pending.delete(found);
            wb_writeback_en <= 1'b1;
            wb_writeback_thread_idx <= idx_bits'(last_wb.thread);
            wb_writeback_reg <= last_wb.regnum;
        end
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        id_instruction = '0;
        id_instruction_valid = 1'b0;
        id_thread_idx = '0;
        thread_en = '1;
        wb_writeback_en = 1'b0;
        wb_writeback_thread_idx = '0;
        wb_writeback_reg = '0;
        for (int t = 0; t < num_threads; t++)
            busy[t] = '0;
        load_table();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < rows.size(); r++)
            apply_row(r);
        @(posedge clk);
        id_instruction_valid <= 1'b0;
        // Drain until every push has issued and every destination has been returned
        while (issued_count < pushed_count || wb_pending.size() != 0 || last_wb_valid)
            @(posedge clk);
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (fetch_en == thread_en)
        else report_mismatch("final_fetch_en", thread_en, fetch_en);
        $display("Errors: %0d value mismatches, %0d other failures",
            mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from the table length, started once reset is released
    initial
    begin
        @(negedge reset);
        #(rows.size() * row_cycles * clk_period);
        $display("Watchdog expired before all instructions issued and retired");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* logic/thread_select_stage.sv */
// Thread select stage top level, joining the queues, scoreboard and arbiter over one issue bus
`timescale 1ns/10ps

module thread_select_stage
    import thread_select_pkg::*;
#(
    parameter int num_threads = 4,
    parameter int fifo_depth = 8
) (
    input  logic                                      clk,
    input  logic                                      reset,

    // Decoded instructions, pushed one per cycle into the named thread's queue
    input  decoded_instr_t                            id_instruction,
    input  logic                                      id_instruction_valid,
    input  logic [thread_idx_bits(num_threads) - 1:0] id_thread_idx,

    // Fetch throttle back to the front end
    output logic [num_threads - 1:0]                  fetch_en,
    input  logic [num_threads - 1:0]                  thread_en,

    // Register writeback from the end of the pipeline
    input  logic                                      wb_writeback_en,
    input  logic [thread_idx_bits(num_threads) - 1:0] wb_writeback_thread_idx,
    input  reg_idx_t                                  wb_writeback_reg,

    // Issue toward operand fetch, with no back-pressure
    output logic                                      ts_instruction_valid,
    output decoded_instr_t                            ts_instruction,
    output logic [thread_idx_bits(num_threads) - 1:0] ts_thread_idx
);

    issue_if #(.num_threads(num_threads)) issue_bus ();

    thread_queues #(
        .num_threads(num_threads),
        .fifo_depth(fifo_depth)
    ) thread_queues_i (
        .clk(clk),
        .reset(reset),
        .id_instruction(id_instruction),
        .id_instruction_valid(id_instruction_valid),
        .id_thread_idx(id_thread_idx),
        .thread_en(thread_en),
        .fetch_en(fetch_en),
        .q(issue_bus.queues)
    );

    register_scoreboard #(.num_threads(num_threads)) register_scoreboard_i (
        .clk(clk),
        .reset(reset),
        .wb_writeback_en(wb_writeback_en),
        .wb_writeback_thread_idx(wb_writeback_thread_idx),
        .wb_writeback_reg(wb_writeback_reg),
        .sb(issue_bus.scoreboard)
    );

    issue_arbiter #(.num_threads(num_threads)) issue_arbiter_i (
        .clk(clk),
        .reset(reset),
        .thread_en(thread_en),
        .ts_instruction_valid(ts_instruction_valid),
        .ts_instruction(ts_instruction),
        .ts_thread_idx(ts_thread_idx),
        .arb(issue_bus.arbiter)
    );

endmodule

/* logic/issue_arbiter.sv */
// Round-robin choice among ready threads and the registered issue output of the stage
`timescale 1ns/10ps

module issue_arbiter
    import thread_select_pkg::*;
#(
    parameter int num_threads = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [num_threads - 1:0]                  thread_en,
    output logic                                      ts_instruction_valid,
    output decoded_instr_t                            ts_instruction,
    output logic [thread_idx_bits(num_threads) - 1:0] ts_thread_idx,
    issue_if.arbiter                                  arb
);

    localparam int idx_bits = thread_idx_bits(num_threads);

    logic [num_threads - 1:0] ready;
    logic [num_threads - 1:0] grant;
    logic [idx_bits - 1:0] grant_idx;
    logic [idx_bits - 1:0] rr_ptr;

    // A disabled thread keeps its slot but never issues
    assign ready = arb.slot_valid & ~arb.dep_conflict & thread_en;

    // Scan from the pointer onward and take the first ready thread
    always_comb
    begin
        int cand;
        logic found;
        grant = '0;
        found = 1'b0;
        for (int k = 0; k < num_threads; k++)
        begin
            cand = (int'(rr_ptr) + k) % num_threads;
            if (!found && ready[cand])
            begin
                grant[cand] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign arb.grant_oh = grant;

    // One-hot to index
    always_comb
    begin
        grant_idx = '0;
        for (int t = 0; t < num_threads; t++)
        begin
            if (grant[t])
                grant_idx = idx_bits'(t);
        end
    end

    always_ff @(posedge clk)
    begin
        ts_instruction <= arb.slot_instr[grant_idx];
        ts_thread_idx <= grant_idx;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ts_instruction_valid <= 1'b0;
            rr_ptr <= '0;
        end
        else
        begin
            ts_instruction_valid <= |grant;

            // The granted thread drops to lowest priority for the next pick
            if (|grant)
                rr_ptr <= (grant_idx == idx_bits'(num_threads - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    // The queues and scoreboard rely on at most one slot leaving per cycle
    assert property (@(posedge clk) disable iff (reset) $onehot0(arb.grant_oh));

endmodule

/* logic/register_scoreboard.sv */
// Per-thread busy register tracking, set on issue and cleared on writeback, reporting slot conflicts
`timescale 1ns/10ps

module register_scoreboard
    import thread_select_pkg::*;
#(
    parameter int num_threads = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      wb_writeback_en,
    input  logic [thread_idx_bits(num_threads) - 1:0] wb_writeback_thread_idx,
    input  reg_idx_t                                  wb_writeback_reg,
    issue_if.scoreboard                               sb
);

    localparam int idx_bits = thread_idx_bits(num_threads);

    for (genvar i = 0; i < num_threads; i++)
    begin : thread_gen
        reg_bitmap_t busy;
        reg_bitmap_t clear_bitmap;
        reg_bitmap_t set_bitmap;
        logic writeback_this;

        assign writeback_this = wb_writeback_en
            && (wb_writeback_thread_idx == idx_bits'(i));

        // A completed result frees exactly one register of one thread
        always_comb
        begin
            clear_bitmap = '0;
            if (writeback_this)
                clear_bitmap[wb_writeback_reg] = 1'b1;
        end

        // An issuing instruction claims its destination
        assign set_bitmap = sb.grant_oh[i] ? sb.dest_bitmap[i] : '0;

        // Set is applied after clear, so a new claim survives a writeback to the same register
        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
                busy <= '0;
            else
                busy <= (busy & ~clear_bitmap) | set_bitmap;
        end

        // Any overlap between what the slot touches and what is pending holds the slot
        assign sb.dep_conflict[i] = |(busy & sb.dep_bitmap[i]);

        // The writeback side may only return results that were issued and not yet retired
        assert property (@(posedge clk) disable iff (reset)
            writeback_this |-> busy[wb_writeback_reg]);
    end

endmodule

/* logic/thread_queues.sv */
// Per-thread instruction queues and issue slots, with the register bitmaps built when a slot fills
`timescale 1ns/10ps

module thread_queues
    import thread_select_pkg::*;
#(
    parameter int num_threads = 4,
    parameter int fifo_depth = 8
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  decoded_instr_t                            id_instruction,
    input  logic                                      id_instruction_valid,
    input  logic [thread_idx_bits(num_threads) - 1:0] id_thread_idx,
    input  logic [num_threads - 1:0]                  thread_en,
    output logic [num_threads - 1:0]                  fetch_en,
    issue_if.queues                                   q
);

    localparam int idx_bits = thread_idx_bits(num_threads);

    for (genvar i = 0; i < num_threads; i++)
    begin : thread_gen
        logic enqueue_this;
        logic latch_en;
        logic fifo_empty;
        logic fifo_almost_full;
        decoded_instr_t fifo_head;
        reg_bitmap_t dest_bitmap_nxt;
        reg_bitmap_t dep_bitmap_nxt;
        logic slot_valid_r;
        decoded_instr_t slot_instr_r;
        reg_bitmap_t dep_bitmap_r;
        reg_bitmap_t dest_bitmap_r;

        // Decode pushes carry the thread they belong to
        assign enqueue_this = id_instruction_valid && (id_thread_idx == idx_bits'(i));

        // Refill the slot whenever it is empty or its instruction leaves this cycle
        assign latch_en = !fifo_empty && (!slot_valid_r || q.grant_oh[i]);

        // The threshold leaves room for the instructions already in flight
        // when fetch_en drops
        instruction_fifo #(
            .width($bits(decoded_instr_t)),
            .depth(fifo_depth),
            .almost_full_threshold(fifo_depth - 3)
        ) instruction_fifo_i (
            .clk(clk),
            .reset(reset),
            .enqueue_en(enqueue_this),
            .value_in(id_instruction),
            .dequeue_en(latch_en),
            .value_out(fifo_head),
            .empty(fifo_empty),
            .almost_full(fifo_almost_full)
        );

        assign fetch_en[i] = !fifo_almost_full && thread_en[i];

        // Destination bitmap is what the scoreboard marks busy on issue
        always_comb
        begin
            dest_bitmap_nxt = '0;
            if (fifo_head.has_dest)
                dest_bitmap_nxt[fifo_head.dest_reg] = 1'b1;
        end

        // Sources catch read-after-write hazards
        // The destination is included too, so a second write waits for the first one
        always_comb
        begin
            dep_bitmap_nxt = '0;
            if (fifo_head.has_dest)
                dep_bitmap_nxt[fifo_head.dest_reg] = 1'b1;
            if (fifo_head.has_src1)
                dep_bitmap_nxt[fifo_head.src1_reg] = 1'b1;
            if (fifo_head.has_src2)
                dep_bitmap_nxt[fifo_head.src2_reg] = 1'b1;
        end

        always_ff @(posedge clk)
        begin
            if (latch_en)
            begin
                slot_instr_r <= fifo_head;
                dep_bitmap_r <= dep_bitmap_nxt;
                dest_bitmap_r <= dest_bitmap_nxt;
            end
        end

        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
                slot_valid_r <= 1'b0;
            else if (latch_en)
                slot_valid_r <= 1'b1;
            else if (q.grant_oh[i])
                slot_valid_r <= 1'b0;
        end

        assign q.slot_valid[i] = slot_valid_r;
        assign q.slot_instr[i] = slot_instr_r;
        assign q.dep_bitmap[i] = dep_bitmap_r;
        assign q.dest_bitmap[i] = dest_bitmap_r;
    end

endmodule

/* logic/instruction_fifo.sv */
// Synchronous circular FIFO with a head shown combinationally and an almost-full flag
`timescale 1ns/10ps

module instruction_fifo #(
    parameter int width = 32,
    parameter int depth = 8,
    parameter int almost_full_threshold = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enqueue_en,
    input  logic [width - 1:0]   value_in,
    input  logic                 dequeue_en,
    output logic [width - 1:0]   value_out,
    output logic                 empty,
    output logic                 almost_full
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);

    logic [width - 1:0] storage [depth];
    logic [ptr_bits - 1:0] rd_ptr;
    logic [ptr_bits - 1:0] wr_ptr;
    logic [count_bits - 1:0] count;

    // Head entry is visible without a read cycle
    assign value_out = storage[rd_ptr];
    assign empty = (count == '0);
    assign almost_full = (count >= count_bits'(almost_full_threshold));

    always_ff @(posedge clk)
    begin
        if (enqueue_en)
            storage[wr_ptr] <= value_in;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so a depth that is not a power of two works
            if (enqueue_en)
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;

            if (dequeue_en)
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;

            // Simultaneous push and pop leave the count unchanged
            if (enqueue_en && !dequeue_en)
                count <= count + 1'b1;
            else if (dequeue_en && !enqueue_en)
                count <= count - 1'b1;
        end
    end

    // The producer has to honour fetch_en early enough that the queue never overflows
    assert property (@(posedge clk) disable iff (reset)
        enqueue_en |-> (count != count_bits'(depth)));

    // The slot logic only pops when the head holds a real entry
    assert property (@(posedge clk) disable iff (reset) dequeue_en |-> !empty);

endmodule

/* logic/issue_if.sv */
// Per-thread slot, conflict and grant signals shared by the queue, scoreboard and arbiter blocks
`timescale 1ns/10ps

interface issue_if
    import thread_select_pkg::*;
#(
    parameter int num_threads = 4
);

    // Slot contents, one entry per thread
    logic [num_threads - 1:0] slot_valid;
    decoded_instr_t slot_instr [num_threads];
    reg_bitmap_t dep_bitmap [num_threads];
    reg_bitmap_t dest_bitmap [num_threads];

    // Set when a slot instruction touches a register that is still pending
    logic [num_threads - 1:0] dep_conflict;

    // The single thread that issues in this cycle, or none
    logic [num_threads - 1:0] grant_oh;

    // The queues fill slots and see which slot is being consumed
    modport queues (output slot_valid, slot_instr, dep_bitmap, dest_bitmap, input grant_oh);

    // The scoreboard marks destinations busy on a grant and checks dependencies
    modport scoreboard (input dep_bitmap, dest_bitmap, grant_oh, output dep_conflict);

    // The arbiter picks among valid, conflict-free slots
    modport arbiter (input slot_valid, slot_instr, dep_conflict, output grant_oh);

endinterface

/* logic/thread_select_pkg.sv */
// Shared widths, register types and the decoded instruction format, imported by the thread select stage
package thread_select_pkg;

    // Number of scalar registers each thread's scoreboard covers
    parameter int num_registers = 32;

    // Register number as carried in the decoded instruction
    typedef logic [$clog2(num_registers) - 1:0] reg_idx_t;

    // One bit per scalar register, used for busy and dependency tracking
    typedef logic [num_registers - 1:0] reg_bitmap_t;

    // Opaque instruction identifier, passed through the stage untouched
    typedef logic [15:0] instr_tag_t;

    // Decoded instruction as delivered by the decode stage
    // Each register field is only meaningful when its has_ flag is set
    typedef struct packed {
        logic has_dest;
        reg_idx_t dest_reg;
        logic has_src1;
        reg_idx_t src1_reg;
        logic has_src2;
        reg_idx_t src2_reg;
        instr_tag_t tag;
    } decoded_instr_t;

    // Width of a thread index for a given thread count
    // A single thread still gets a one bit index so that ports keep a legal width
    function automatic int thread_idx_bits(input int num_threads);
        int bits;
        if (num_threads > 1)
        begin
            bits = $clog2(num_threads);
        end
        else
        begin
            bits = 1;
        end
        return bits;
    endfunction

endpackage
